// File: common/wr_cred_pkg.sv
/* shared widths and packed types for the write side of the remote credit block.
   modules refer to these by scoped names. */

package wr_cred_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int DATA_W = 64; // payload beat width.
  localparam int LEN_W  = 8;  // request length in beats.
  localparam int DEST_W = 4;  // destination index.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request and stream types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // write request, also used for packet requests and routes.
  typedef struct packed {
    logic [DEST_W-1:0] dest; // target data port.
    logic [LEN_W-1:0]  len;  // beats to move.
  } wr_req_t;

  // one stream beat.
  // last marks the final beat of a packet on the destination side.
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } axis_beat_t;

endpackage

// File: credits/req_splitter.sv
/* splits each queued write request into packet requests of at most PKT_BEATS beats.
   all packets but the last are full; zero length requests are dropped. */

`timescale 1ns/100ps

module req_splitter #(
  parameter int PKT_BEATS = 8
) (
  input  logic                 aclk,
  input  logic                 rst,
  input  wr_cred_pkg::wr_req_t q_req,
  input  logic                 q_req_valid,
  output logic                 q_req_ready,
  output wr_cred_pkg::wr_req_t pkt_req,
  output logic                 pkt_req_valid,
  input  logic                 pkt_req_ready
);

  localparam int LW = wr_cred_pkg::LEN_W;
  localparam logic [LW-1:0] PKT_LEN = LW'(PKT_BEATS);

  wr_cred_pkg::wr_req_t pkt_r; // packet on the output.
  logic                 pkt_v;
  logic [LW-1:0]        rem;    // beats left after the current packet.
  logic [LW-1:0]        take_q; // first packet size of a new request.
  logic [LW-1:0]        take_r; // next packet size from the remainder.
  logic                 accept;
  logic                 sent;

  assign take_q = (q_req.len > PKT_LEN) ? PKT_LEN : q_req.len;
  assign take_r = (rem > PKT_LEN) ? PKT_LEN : rem;

  // next request only once the last packet has left.
  assign q_req_ready = !pkt_v;
  assign accept      = q_req_valid && q_req_ready;
  assign sent        = pkt_v && pkt_req_ready;

  assign pkt_req       = pkt_r;
  assign pkt_req_valid = pkt_v;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge aclk) begin
    if (rst) begin
      pkt_v <= 1'b0;
      rem   <= '0;
    end else if (accept) begin
      pkt_v <= (q_req.len != '0); // empty request is consumed here.
      rem   <= q_req.len - take_q;
    end else if (sent) begin
      pkt_v <= (rem != '0); // more packets pending.
      rem   <= rem - take_r;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // packet payload
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge aclk) begin
    if (accept) begin
      pkt_r.dest <= q_req.dest;
      pkt_r.len  <= take_q;
    end else if (sent && (rem != '0)) begin
      pkt_r.len <= take_r; // same dest, next slice.
    end
  end

endmodule

// File: credits/wr_credit_gate.sv
/* credit gate between splitter and the network request port.
   counts buffered beats and releases a packet request only when all its data is held. */

`timescale 1ns/100ps

module wr_credit_gate #(
  parameter int DDEPTH = 64
) (
  input  logic                 aclk,
  input  logic                 rst,
  input  wr_cred_pkg::wr_req_t pkt_req,
  input  logic                 pkt_req_valid,
  output logic                 pkt_req_ready,
  input  logic                 wr_beat,
  output wr_cred_pkg::wr_req_t m_req,
  output logic                 m_req_valid,
  input  logic                 m_req_ready,
  output wr_cred_pkg::wr_req_t route,
  output logic                 route_valid,
  input  logic                 route_ready
);

  localparam int LW     = wr_cred_pkg::LEN_W;
  localparam int CRED_W = $clog2(DDEPTH + 1); // credits never exceed the buffer.
  localparam int CMP_W  = LW + CRED_W;

  wr_cred_pkg::wr_req_t hold_r; // packet waiting for credits.
  logic                 hold_v;
  logic [CRED_W-1:0]    credits;
  logic [CMP_W-1:0]     have;
  logic [CMP_W-1:0]     need;
  logic                 enough;
  logic                 fire;

  assign have   = CMP_W'(credits);
  assign need   = CMP_W'(hold_r.len);
  assign enough = (have >= need);

  // release only when the network port and the mux take it together.
  // both sides transfer in the same cycle.
  assign fire = hold_v && enough && m_req_ready && route_ready;

  assign m_req       = hold_r;
  assign m_req_valid = fire;
  assign route       = hold_r; // copy for the data mux.
  assign route_valid = fire;

  assign pkt_req_ready = !hold_v; // one packet in flight at a time.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // hold register and credits
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge aclk) begin
    if (rst) begin
      hold_v  <= 1'b0;
      credits <= '0;
    end else begin
      if (pkt_req_valid && pkt_req_ready) begin
        hold_v <= 1'b1;
      end else if (fire) begin
        hold_v <= 1'b0;
      end
      // one up per buffered beat, len down per release.
      credits <= credits + CRED_W'(wr_beat) - (fire ? CRED_W'(hold_r.len) : '0);
    end
  end

  always_ff @(posedge aclk) begin
    if (pkt_req_valid && pkt_req_ready) begin
      hold_r <= pkt_req;
    end
  end

endmodule

// File: rtl/data_fifo.sv
/* payload buffer for the write stream, first word fall through.
   wr_beat pulses once per stored beat and feeds the credit counter. */

`timescale 1ns/100ps

module data_fifo #(
  parameter int DDEPTH = 64
) (
  input  logic                                 aclk,
  input  logic                                 rst,
  input  logic [wr_cred_pkg::DATA_W-1:0]       s_axis_data,
  input  logic                                 s_axis_valid,
  output logic                                 s_axis_ready,
  output logic                                 wr_beat,
  output wr_cred_pkg::axis_beat_t              buf_beat,
  output logic                                 buf_valid,
  input  logic                                 buf_ready
);

  localparam int DW    = wr_cred_pkg::DATA_W;
  localparam int PTR_W = (DDEPTH > 1) ? $clog2(DDEPTH) : 1;
  localparam int CNT_W = $clog2(DDEPTH + 1);

  logic [DW-1:0]    mem [DDEPTH]; // data only, last is rebuilt downstream.
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign push = s_axis_valid && s_axis_ready;
  assign pop  = buf_valid && buf_ready;

  assign s_axis_ready  = (count != CNT_W'(DDEPTH));
  assign buf_valid     = (count != '0); // head shows the cycle after the write.
  assign buf_beat.data = mem[rd_ptr];
  assign buf_beat.last = 1'b0; // the mux sets last.

  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= s_axis_data;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pointers, count, credit pulse
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge aclk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      wr_beat <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DDEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DDEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count   <= count + CNT_W'(push) - CNT_W'(pop);
      wr_beat <= push; // credit lands with the beat at the head side.
    end
  end

endmodule

// File: rtl/dest_data_mux.sv
/* steers buffered beats to one destination port per released route.
   moves exactly len beats and marks the final one with last. */

`timescale 1ns/100ps

module dest_data_mux #(
  parameter int N_DESTS = 4
) (
  input  logic                    aclk,
  input  logic                    rst,
  input  wr_cred_pkg::wr_req_t    route,
  input  logic                    route_valid,
  output logic                    route_ready,
  input  wr_cred_pkg::axis_beat_t buf_beat,
  input  logic                    buf_valid,
  output logic                    buf_ready,
  output wr_cred_pkg::axis_beat_t m_axis [N_DESTS],
  output logic [N_DESTS-1:0]      m_axis_valid,
  input  logic [N_DESTS-1:0]      m_axis_ready
);

  localparam int LW = wr_cred_pkg::LEN_W;
  localparam int DW = wr_cred_pkg::DEST_W;

  logic          busy;   // a route is active.
  logic [DW-1:0] dest_r; // active destination.
  logic [LW-1:0] left_r; // beats still to send.
  logic          last_b;
  logic          sel_ready;
  logic          beat_go;

  assign route_ready = !busy;
  assign last_b      = (left_r == LW'(1));

  // ready of the chosen port only.
  always_comb begin
    sel_ready = 1'b0;
    for (int i = 0; i < N_DESTS; i++) begin
      if (dest_r == DW'(i)) begin
        sel_ready = m_axis_ready[i];
      end
    end
  end

  assign buf_ready = busy && sel_ready; // a stalled port holds the whole buffer.
  assign beat_go   = buf_valid && buf_ready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // output ports
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar i = 0; i < N_DESTS; i++) begin : g_port
    assign m_axis[i].data  = buf_beat.data;
    assign m_axis[i].last  = last_b;
    assign m_axis_valid[i] = busy && buf_valid && (dest_r == DW'(i));
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // route tracking
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge aclk) begin
    if (rst) begin
      busy   <= 1'b0;
      left_r <= '0;
    end else if (route_valid && route_ready) begin
      busy   <= 1'b1; // routes carry at least one beat.
      left_r <= route.len;
    end else if (beat_go) begin
      left_r <= left_r - 1'b1;
      if (last_b) begin
        busy <= 1'b0; // idle, next route from the following cycle.
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (route_valid && route_ready) begin
      dest_r <= route.dest;
    end
  end

endmodule

// File: rtl/remote_credits_wr.sv
/* write side of the remote credit block.
   queue, splitter and credit gate on the request path, data buffer and destination mux. */

`timescale 1ns/100ps

module remote_credits_wr #(
  parameter int N_DESTS   = 4,
  parameter int QDEPTH    = 4,
  parameter int PKT_BEATS = 8,
  parameter int DDEPTH    = 64
) (
  input  logic                           aclk,
  input  logic                           rst,
  input  wr_cred_pkg::wr_req_t           s_req,
  input  logic                           s_req_valid,
  output logic                           s_req_ready,
  input  logic [wr_cred_pkg::DATA_W-1:0] s_axis_data,
  input  logic                           s_axis_valid,
  output logic                           s_axis_ready,
  output wr_cred_pkg::wr_req_t           m_req,
  output logic                           m_req_valid,
  input  logic                           m_req_ready,
  output wr_cred_pkg::axis_beat_t        m_axis [N_DESTS],
  output logic [N_DESTS-1:0]             m_axis_valid,
  input  logic [N_DESTS-1:0]             m_axis_ready
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // producer side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  wr_cred_pkg::wr_req_t    q_req;   // queue head.
  logic                    q_req_valid;
  logic                    q_req_ready;
  wr_cred_pkg::wr_req_t    pkt_req; // split packets.
  logic                    pkt_req_valid;
  logic                    pkt_req_ready;
  wr_cred_pkg::wr_req_t    route;   // released copy for the mux.
  logic                    route_valid;
  logic                    route_ready;
  logic                    wr_beat;
  wr_cred_pkg::axis_beat_t buf_beat;
  logic                    buf_valid;
  logic                    buf_ready;

  req_queue #(.QDEPTH(QDEPTH)) inst_queue (
    .aclk(aclk), .rst(rst),
    .s_req(s_req), .s_req_valid(s_req_valid), .s_req_ready(s_req_ready),
    .q_req(q_req), .q_req_valid(q_req_valid), .q_req_ready(q_req_ready)
  );

  req_splitter #(.PKT_BEATS(PKT_BEATS)) inst_split (
    .aclk(aclk), .rst(rst),
    .q_req(q_req), .q_req_valid(q_req_valid), .q_req_ready(q_req_ready),
    .pkt_req(pkt_req), .pkt_req_valid(pkt_req_valid), .pkt_req_ready(pkt_req_ready)
  );

  wr_credit_gate #(.DDEPTH(DDEPTH)) inst_cred (
    .aclk(aclk), .rst(rst),
    .pkt_req(pkt_req), .pkt_req_valid(pkt_req_valid), .pkt_req_ready(pkt_req_ready),
    .wr_beat(wr_beat),
    .m_req(m_req), .m_req_valid(m_req_valid), .m_req_ready(m_req_ready),
    .route(route), .route_valid(route_valid), .route_ready(route_ready)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // buffer and consumer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  data_fifo #(.DDEPTH(DDEPTH)) inst_buf (
    .aclk(aclk), .rst(rst),
    .s_axis_data(s_axis_data), .s_axis_valid(s_axis_valid), .s_axis_ready(s_axis_ready),
    .wr_beat(wr_beat),
    .buf_beat(buf_beat), .buf_valid(buf_valid), .buf_ready(buf_ready)
  );

  dest_data_mux #(.N_DESTS(N_DESTS)) inst_mux (
    .aclk(aclk), .rst(rst),
    .route(route), .route_valid(route_valid), .route_ready(route_ready),
    .buf_beat(buf_beat), .buf_valid(buf_valid), .buf_ready(buf_ready),
    .m_axis(m_axis), .m_axis_valid(m_axis_valid), .m_axis_ready(m_axis_ready)
  );

endmodule

// File: rtl/req_queue.sv
/* request queue in front of the packet splitter.
   small circular buffer with valid/ready on both sides. */

`timescale 1ns/100ps

module req_queue #(
  parameter int QDEPTH = 4
) (
  input  logic                 aclk,
  input  logic                 rst,
  input  wr_cred_pkg::wr_req_t s_req,
  input  logic                 s_req_valid,
  output logic                 s_req_ready,
  output wr_cred_pkg::wr_req_t q_req,
  output logic                 q_req_valid,
  input  logic                 q_req_ready
);

  localparam int PTR_W = (QDEPTH > 1) ? $clog2(QDEPTH) : 1;
  localparam int CNT_W = $clog2(QDEPTH + 1);

  wr_cred_pkg::wr_req_t mem [QDEPTH]; // request storage.

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count; // entries held.
  logic             push;
  logic             pop;

  assign push = s_req_valid && s_req_ready;
  assign pop  = q_req_valid && q_req_ready;

  assign s_req_ready = (count != CNT_W'(QDEPTH)); // full stalls the client.
  assign q_req_valid = (count != '0);
  assign q_req       = mem[rd_ptr]; // head of queue.

  // write into the tail entry.
  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= s_req;
    end
  end

  // pointers and occupancy.
  always_ff @(posedge aclk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(QDEPTH - 1)) ? '0 : wr_ptr + 1'b1; // wrap.
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(QDEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop); // push and pop together cancel.
    end
  end

endmodule

// File: src.f
common/wr_cred_pkg.sv
rtl/req_queue.sv
credits/req_splitter.sv
credits/wr_credit_gate.sv
rtl/data_fifo.sv
rtl/dest_data_mux.sv
rtl/remote_credits_wr.sv
tests/remote_credits_wr_checker.sv
tests/tb_remote_credits_wr.sv

// File: tests/remote_credits_wr_checker.sv
/* handshake and routing assertions, bound into the top level.
   covers output hold under back-pressure, m_req with route, one active port. */

`timescale 1ns/100ps

module remote_credits_wr_checker #(
  parameter int N_DESTS = 4
) (
  input logic                    aclk,
  input logic                    rst,
  input logic                    m_req_valid,
  input logic                    route_valid,
  input wr_cred_pkg::axis_beat_t m_axis [N_DESTS],
  input logic [N_DESTS-1:0]      m_axis_valid,
  input logic [N_DESTS-1:0]      m_axis_ready
);

  int n_fail = 0; // failed assertions so far.

  // network request and mux route leave together.
  a_req_route: assert property (@(posedge aclk) disable iff (rst)
    m_req_valid |-> route_valid)
    else begin
      $error("m_req valid without route valid");
      n_fail++;
    end

  a_one_port: assert property (@(posedge aclk) disable iff (rst)
    $onehot0(m_axis_valid))
    else begin
      $error("more than one data port valid");
      n_fail++;
    end

  for (genvar i = 0; i < N_DESTS; i++) begin : g_hold
    a_beat_hold: assert property (@(posedge aclk) disable iff (rst)
      m_axis_valid[i] && !m_axis_ready[i] |=> m_axis_valid[i] && $stable(m_axis[i]))
      else begin
        $error("beat on port %0d changed or dropped while stalled", i);
        n_fail++;
      end
  end

endmodule

bind remote_credits_wr remote_credits_wr_checker #(.N_DESTS(N_DESTS)) chk0 (
  .aclk(aclk), .rst(rst),
  .m_req_valid(m_req_valid),
  .route_valid(route_valid),
  .m_axis(m_axis), .m_axis_valid(m_axis_valid), .m_axis_ready(m_axis_ready)
);

// File: tests/tb_remote_credits_wr.sv
/* trace driven testbench for the write side of the remote credit block.
   reads tests/wr_trace.txt, drives requests and payload, checks m_req and every output beat. */

`timescale 1ns/100ps

module tb_remote_credits_wr;

  localparam int N_DESTS   = 4;
  localparam int PKT_BEATS = 8;
  localparam int TMAX      = 64; // trace records.

  logic                    aclk;
  logic                    rst;
  wr_cred_pkg::wr_req_t    s_req;
  logic                    s_req_valid;
  logic                    s_req_ready;
  logic [63:0]             s_axis_data;
  logic                    s_axis_valid;
  logic                    s_axis_ready;
  wr_cred_pkg::wr_req_t    m_req;
  logic                    m_req_valid;
  logic                    m_req_ready;
  wr_cred_pkg::axis_beat_t m_axis [N_DESTS];
  logic [N_DESTS-1:0]      m_axis_valid;
  logic [N_DESTS-1:0]      m_axis_ready;

  logic [79:0] trace [TMAX];  // kind, id, payload.
  logic [79:0] exp_req [$];   // {dest, len}.
  logic [79:0] exp_beat [$];  // {dest, last, data} in stream order.
  logic [11:0] t_reqs [$];    // requests of the running test.
  logic [63:0] t_data [$];    // payload of the running test.
  integer      seed;
  logic        bp_on;         // random ready on the outputs.
  int          errors;
  int          n_tests;
  int          reqs_sent;
  int          beats_in;
  int          beats_out;
  int          released;

  remote_credits_wr #(.N_DESTS(N_DESTS), .PKT_BEATS(PKT_BEATS)) dut0 (.*);

  always #10 aclk = ~aclk; // 20 ns period.

  task automatic check(input logic [79:0] got, input logic [79:0] exp, input string msg);
    if (got !== exp) begin
      $display("error at %0t: %s, got %h expected %h", $time, msg, got, exp);
      errors++;
    end
  endtask

  function automatic int idle_gap();
    return $unsigned($random(seed)) % 3; // 0 to 2 idle cycles.
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // drivers for the falling edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic send_req(input wr_cred_pkg::wr_req_t r);
    s_req       = r;
    s_req_valid = 1'b1;
    while (!s_req_ready) @(negedge aclk); // ready does not depend on valid.
    @(negedge aclk);                      // taken on the rising edge in between.
    s_req_valid = 1'b0;
  endtask

  task automatic send_beat(input logic [63:0] w);
    s_axis_data  = w;
    s_axis_valid = 1'b1;
    while (!s_axis_ready) @(negedge aclk);
    @(negedge aclk);
    s_axis_valid = 1'b0;
  endtask

  task automatic run_test(input logic [7:0] id, input logic bp);
    int         base_err;
    int         d;
    logic [7:0] rem;
    logic [7:0] take;
    base_err = errors;
    d        = 0;
    // expected packets and beats from the split rule.
    foreach (t_reqs[r]) begin
      rem = t_reqs[r][7:0];
      while (rem != 0) begin
        take = (rem > 8'(PKT_BEATS)) ? 8'(PKT_BEATS) : rem;
        exp_req.push_back({t_reqs[r][11:8], take});
        for (int k = 0; k < int'(take); k++) begin
          exp_beat.push_back({t_reqs[r][11:8], (k == int'(take) - 1), t_data[d]});
          d++;
        end
        rem -= take;
      end
    end
    bp_on     = bp;
    reqs_sent = 0;
    fork
      begin
        foreach (t_reqs[r]) begin
          repeat (idle_gap()) @(negedge aclk);
          send_req(t_reqs[r]);
          reqs_sent++;
        end
      end
      begin
        while (reqs_sent == 0) @(negedge aclk); // payload follows its request.
        foreach (t_data[j]) begin
          repeat (idle_gap()) @(negedge aclk);
          send_beat(t_data[j]);
        end
      end
    join
    while (exp_req.size() != 0 || exp_beat.size() != 0) @(negedge aclk);
    if (errors == base_err) begin
      $display("test %0d ok: %0d requests, %0d beats", id, t_reqs.size(), t_data.size());
    end else begin
      $display("test %0d failed with %0d errors", id, errors - base_err);
    end
    bp_on = 1'b0;
    n_tests++;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // back-pressure and scoreboard
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(negedge aclk) begin
    if (bp_on) begin
      m_req_ready = ($random(seed) & 3) != 0; // ready about three cycles in four.
      for (int p = 0; p < N_DESTS; p++) begin
        m_axis_ready[p] = ($random(seed) & 3) != 0;
      end
    end else begin
      m_req_ready  = 1'b1;
      m_axis_ready = '1;
    end
  end

  always @(posedge aclk) begin
    logic [79:0] e;
    if (!rst) begin
      if (m_req_valid && m_req_ready) begin
        released += m_req.len;
        if (exp_req.size() == 0) begin
          $display("unexpected m_req to dest %0d with len %0d at %0t", m_req.dest, m_req.len,
                   $time);
          errors++;
        end else begin
          e = exp_req.pop_front();
          check(80'(m_req), e, "m_req dest and len");
        end
        // every released beat must already be accepted on s_axis.
        check(80'(released <= beats_in), 80'd1, "m_req ahead of its payload");
      end
      for (int p = 0; p < N_DESTS; p++) begin
        if (m_axis_valid[p] && m_axis_ready[p]) begin
          beats_out++;
          if (exp_beat.size() == 0) begin
            $display("unexpected beat on port %0d at %0t", p, $time);
            errors++;
          end else begin
            e = exp_beat.pop_front();
            check({p[3:0], m_axis[p].last, m_axis[p].data}, e, "beat dest, last and data");
          end
        end
      end
      if (s_axis_valid && s_axis_ready) beats_in++;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // main sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    int         i;
    int         n_beats;
    int         limit;
    logic [7:0] id;
    logic       bp;
    aclk         = 1'b0;
    rst          = 1'b1;
    s_req        = '0;
    s_req_valid  = 1'b0;
    s_axis_data  = '0;
    s_axis_valid = 1'b0;
    m_req_ready  = 1'b1;
    m_axis_ready = '1;
    bp_on        = 1'b0;
    seed         = 32'hf4c6_0aad;
    errors       = 0;
    n_tests      = 0;
    beats_in     = 0;
    beats_out    = 0;
    released     = 0;
    for (i = 0; i < TMAX; i++) trace[i] = '0; // empty records end the trace.
    $readmemh("tests/wr_trace.txt", trace);
    n_beats = 0;
    for (i = 0; i < TMAX; i++) if (trace[i][79:72] == 8'h02) n_beats++;
    limit = 200 * n_beats + 1000;
    fork
      begin
        repeat (limit) @(posedge aclk);
        $display("run timed out after %0d cycles with outputs still pending", limit);
        $display("TEST FAIL");
        $finish;
      end
    join_none
    repeat (5) @(posedge aclk);
    @(negedge aclk);
    rst = 1'b0;
    i   = 0;
    while (i < TMAX && trace[i][79:72] != 8'h00) begin
      id = trace[i][71:64];
      bp = 1'b0;
      t_reqs.delete();
      t_data.delete();
      // gather the records of one test id.
      while (i < TMAX && trace[i][79:72] != 8'h00 && trace[i][71:64] == id) begin
        if (trace[i][79:72] == 8'h01) begin
          t_reqs.push_back(trace[i][11:0]);
          bp = bp | trace[i][63];
        end else begin
          t_data.push_back(trace[i][63:0]);
        end
        i++;
      end
      run_test(id, bp);
    end
    check(80'(beats_out), 80'(beats_in), "total beats out against beats in");
    check(80'(dut0.chk0.n_fail), 80'd0, "assertion failures in the bound checker");
    $display("%0d tests, %0d beats in, %0d beats out, %0d errors", n_tests, beats_in,
             beats_out, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: tests/wr_trace.txt
// kind(2) id(2) payload(16). kind 01 request: payload bit 63 back-pressure, [11:8] dest, [7:0] len
// kind 02 data beat in stream order, payload is the word
01010000000000000102
02011111000000000001
02011111000000000002
01020000000000000209
02022222000000000001
02022222000000000002
02022222000000000003
02022222000000000004
02022222000000000005
02022222000000000006
02022222000000000007
02022222000000000008
02022222000000000009
01030000000000000001
02033333000000000001
01040000000000000301
01040000000000000001
02044444000000000001
02044444000000000002
01058000000000000102
01058000000000000202
02055555000000000001
02055555000000000002
02055555000000000003
02055555000000000004
01060000000000000300
01060000000000000301
02066666000000000001
